//--- div_restoring.sv
//********************
// Iterative restoring unsigned divider. One quotient bit per cycle,
// results held until the next start.
//********************

`default_nettype none

module div_restoring import muldiv_pkg::*; (
    input  logic  clk,
    input  logic  rstLow,
    input  logic  start_i,     // Latch operands and begin.
    input  data_t dividend_i,  // Unsigned dividend.
    input  data_t divisor_i,   // Unsigned divisor, never zero here.
    output data_t quot_o,      // Quotient, valid when idle.
    output data_t rem_o,       // Remainder, valid when idle.
    output logic  busy_o       // High for DIV_STEPS cycles.
);

    div_state_e           state_q;    // Idle or running.
    logic [DIV_CNT_W-1:0] cnt_q;      // Steps done so far.
    data_t                quot_q;     // Dividend shifts out, quotient in.
    data_t                rem_q;      // Partial remainder.
    data_t                divisor_q;  // Latched divisor.
    logic [DATA_WIDTH:0]  shifted;    // Remainder with next dividend bit.
    logic [DATA_WIDTH:0]  trial;      // Shifted remainder minus divisor.

    // ********************
    // Datapath step
    // ********************
    assign shifted = {rem_q, quot_q[DATA_WIDTH-1]};
    assign trial   = shifted - {1'b0, divisor_q};  // MSB set means it went negative.

    always_ff @(posedge clk) begin
        if (start_i) begin
            quot_q    <= dividend_i;
            rem_q     <= '0;
            divisor_q <= divisor_i;
        end else if (state_q == DIV_RUN) begin
            if (!trial[DATA_WIDTH]) begin
                rem_q  <= trial[DATA_WIDTH-1:0];   // Subtraction fits.
                quot_q <= {quot_q[DATA_WIDTH-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[DATA_WIDTH-1:0];  // Restore.
                quot_q <= {quot_q[DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

    // ********************
    // Control FSM
    // ********************
    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_RUN;
                        cnt_q   <= '0;
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == DIV_CNT_W'(DIV_STEPS - 1)) begin
                        state_q <= DIV_IDLE;  // Last step on this edge.
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    assign busy_o = (state_q == DIV_RUN);
    assign quot_o = quot_q;
    assign rem_o  = rem_q;

    a_no_restart : assert property (
        @(posedge clk) disable iff (!rstLow) (state_q == DIV_RUN) |-> !start_i);

    a_cnt_range : assert property (
        @(posedge clk) disable iff (!rstLow) cnt_q <= DIV_CNT_W'(DIV_STEPS));

endmodule

`default_nettype wire

//--- muldiv_execute.sv
//********************
// Stage 2 of the multiply/divide unit. Unsigned multiplier, divider
// start control with operand reuse, and the busy flag.
//********************

`default_nettype none

module muldiv_execute import muldiv_pkg::*; (
    input  logic   clk,
    input  logic   rstLow,
    input  logic   start_i,   // Start strobe from the core.
    input  logic   is_div_i,  // Divide or remainder operation.
    input  logic   div0_i,    // Division by zero, no divider run.
    input  logic   ovf_i,     // Signed overflow, no divider run.
    input  data_t  op_a_i,    // Unsigned operand A.
    input  data_t  op_b_i,    // Unsigned operand B.
    output dword_t prod_o,    // Full unsigned product.
    output data_t  quot_o,    // Unsigned quotient.
    output data_t  rem_o,     // Unsigned remainder.
    output logic   busy_o     // Core must wait while high.
);

    data_t prev_a_q;   // Dividend of the last divider start.
    data_t prev_b_q;   // Divisor of the last divider start.
    logic  started_q;  // A start was already issued in this busy period.
    logic  ops_match;  // Stored quotient and remainder still apply.
    logic  div_start;  // One-cycle start pulse to the divider.
    logic  div_busy;   // Divider is iterating.

    // Single-cycle unsigned multiply.
    assign prod_o = dword_t'(op_a_i) * dword_t'(op_b_i);

    // ********************
    // Divider start logic
    // ********************
    // The divider keeps both results, so a REM after a DIV with the
    // same magnitudes needs no new run. Signs are fixed in stage 3.
    assign ops_match = (op_a_i == prev_a_q) && (op_b_i == prev_b_q);

    assign div_start = start_i && is_div_i && !div0_i && !ovf_i
                       && !ops_match && !started_q;

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            prev_a_q <= '0;  // 0/0 is div0, so no false match.
            prev_b_q <= '0;
        end else if (div_start) begin
            prev_a_q <= op_a_i;
            prev_b_q <= op_b_i;
        end
    end

    // Set by a start, cleared once the divider has gone idle.
    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            started_q <= 1'b0;
        end else begin
            started_q <= started_q ? div_busy : div_start;
        end
    end

    // Busy rises in the start cycle to stall the core at once.
    assign busy_o = div_start | div_busy;

    div_restoring u_div (
        .clk        (clk),
        .rstLow     (rstLow),
        .start_i    (div_start),
        .dividend_i (op_a_i),
        .divisor_i  (op_b_i),
        .quot_o     (quot_o),
        .rem_o      (rem_o),
        .busy_o     (div_busy)
    );

    // A start while the divider runs would corrupt its result.
    a_no_start_busy : assert property (
        @(posedge clk) disable iff (!rstLow) !(div_start && div_busy));

endmodule

`default_nettype wire

//--- muldiv_pkg.sv
//********************
// M extension multiply/divide unit: shared widths, opcode
// encodings and divider FSM states.
//********************

`default_nettype none

package muldiv_pkg;

    // ********************
    // Widths and counts
    // ********************
    localparam int DATA_WIDTH = 32;          // Operand and result width.
    localparam int DIV_STEPS  = DATA_WIDTH;  // One quotient bit per divider step.
    localparam int DIV_CNT_W  = 6;           // Must hold DIV_STEPS itself.

    typedef logic [DATA_WIDTH-1:0]   data_t;   // Operand or result word.
    typedef logic [2*DATA_WIDTH-1:0] dword_t;  // Full product.

    // ********************
    // Encodings
    // ********************
    // funct3 values of the M extension.
    typedef enum logic [2:0] {
        MUL    = 3'd0,  // SxS low word.
        MULH   = 3'd1,  // SxS high word.
        MULHSU = 3'd2,  // SxU high word.
        MULHU  = 3'd3,  // UxU high word.
        DIV    = 3'd4,  // Signed quotient.
        DIVU   = 3'd5,  // Unsigned quotient.
        REM    = 3'd6,  // Signed remainder.
        REMU   = 3'd7   // Unsigned remainder.
    } muldiv_op_e;

    // Divider control.
    typedef enum logic {
        DIV_IDLE = 1'b0,  // Waiting for start, results held.
        DIV_RUN  = 1'b1   // Shift-subtract steps in progress.
    } div_state_e;

endpackage

`default_nettype wire

//--- muldiv_top.sv
//********************
// RISC-V M extension multiply/divide unit. Operand preparation,
// execute and result selection in a chain.
//********************

`default_nettype none

module muldiv_top import muldiv_pkg::*; (
    input  data_t      rs1_i,     // Multiplicand or dividend.
    input  data_t      rs2_i,     // Multiplier or divisor.
    input  muldiv_op_e funct3_i,  // Operation select.
    input  logic       start_i,   // Start strobe, pulse or level.
    input  logic       clk,
    input  logic       rstLow,
    output data_t      c_o,       // Result, valid when not busy.
    output logic       busy_o     // Divider in progress.
);

    data_t  op_a, op_b;  // Unsigned operands.
    logic   is_div;
    logic   neg_prod, neg_quot, neg_rem;
    logic   div0, ovf;   // Special cases.
    dword_t prod;
    data_t  quot, rem;

    operand_prep u_prep (
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .funct3_i   (funct3_i),
        .op_a_o     (op_a),
        .op_b_o     (op_b),
        .is_div_o   (is_div),
        .neg_prod_o (neg_prod),
        .neg_quot_o (neg_quot),
        .neg_rem_o  (neg_rem),
        .div0_o     (div0),
        .ovf_o      (ovf)
    );

    muldiv_execute u_exec (
        .clk      (clk),
        .rstLow   (rstLow),
        .start_i  (start_i),
        .is_div_i (is_div),
        .div0_i   (div0),
        .ovf_i    (ovf),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .prod_o   (prod),
        .quot_o   (quot),
        .rem_o    (rem),
        .busy_o   (busy_o)
    );

    result_select u_sel (
        .funct3_i   (funct3_i),
        .rs1_i      (rs1_i),
        .prod_i     (prod),
        .quot_i     (quot),
        .rem_i      (rem),
        .neg_prod_i (neg_prod),
        .neg_quot_i (neg_quot),
        .neg_rem_i  (neg_rem),
        .div0_i     (div0),
        .ovf_i      (ovf),
        .c_o        (c_o)
    );

endmodule

`default_nettype wire

//--- operand_prep.sv
//********************
// Stage 1 of the multiply/divide unit. Decodes the opcode, takes
// absolute values of signed operands and flags the special cases.
//********************

`default_nettype none

module operand_prep import muldiv_pkg::*; (
    input  data_t      rs1_i,       // Multiplicand or dividend.
    input  data_t      rs2_i,       // Multiplier or divisor.
    input  muldiv_op_e funct3_i,    // Operation select.
    output data_t      op_a_o,      // Unsigned magnitude of rs1.
    output data_t      op_b_o,      // Unsigned magnitude of rs2.
    output logic       is_div_o,    // Divide or remainder operation.
    output logic       neg_prod_o,  // Product must be negated.
    output logic       neg_quot_o,  // Quotient must be negated.
    output logic       neg_rem_o,   // Remainder must be negated.
    output logic       div0_o,      // Division by zero.
    output logic       ovf_o        // Signed overflow, DIV and REM only.
);

    localparam data_t MOST_NEG = {1'b1, {(DATA_WIDTH-1){1'b0}}};

    logic  rs1_signed;  // rs1 is treated as two's complement.
    logic  rs2_signed;  // rs2 is treated as two's complement.
    logic  a_neg;       // rs1 is signed and negative.
    logic  b_neg;       // rs2 is signed and negative.
    logic  signed_div;  // DIV or REM.

    // ********************
    // Signedness decode
    // ********************
    // rs1 is unsigned only for the pure unsigned variants.
    assign rs1_signed = !(funct3_i inside {MULHU, DIVU, REMU});
    // rs2 is signed only when both operands are signed.
    assign rs2_signed = funct3_i inside {MUL, MULH, DIV, REM};
    assign signed_div = funct3_i inside {DIV, REM};
    assign is_div_o   = funct3_i[2];  // Upper half of the opcode space.

    assign a_neg = rs1_signed & rs1_i[DATA_WIDTH-1];
    assign b_neg = rs2_signed & rs2_i[DATA_WIDTH-1];

    // Absolute values. The most negative value maps onto 2^31,
    // which is still correct as an unsigned magnitude.
    assign op_a_o = a_neg ? (~rs1_i + data_t'(1)) : rs1_i;
    assign op_b_o = b_neg ? (~rs2_i + data_t'(1)) : rs2_i;

    // ********************
    // Sign fixups
    // ********************
    assign neg_prod_o = a_neg ^ b_neg;  // Product sign.
    assign neg_quot_o = a_neg ^ b_neg;  // Quotient follows the same rule.
    assign neg_rem_o  = a_neg;          // Remainder takes the dividend sign.

    // Special cases, decided on the raw operands.
    assign div0_o = is_div_o && (rs2_i == '0);
    assign ovf_o  = signed_div && (rs1_i == MOST_NEG) && (rs2_i == '1);

endmodule

`default_nettype wire

//--- result_select.sv
//********************
// Stage 3 of the multiply/divide unit. Sign correction, special-case
// results and the output mux.
//********************

`default_nettype none

module result_select import muldiv_pkg::*; (
    input  muldiv_op_e funct3_i,    // Operation select.
    input  data_t      rs1_i,       // Raw dividend for special cases.
    input  dword_t     prod_i,      // Unsigned product.
    input  data_t      quot_i,      // Unsigned quotient.
    input  data_t      rem_i,       // Unsigned remainder.
    input  logic       neg_prod_i,  // Negate the product.
    input  logic       neg_quot_i,  // Negate the quotient.
    input  logic       neg_rem_i,   // Negate the remainder.
    input  logic       div0_i,      // Division by zero.
    input  logic       ovf_i,       // Signed overflow.
    output data_t      c_o          // Result word.
);

    dword_t prod_s;  // Signed product.
    data_t  quot_s;  // Signed quotient.
    data_t  rem_s;   // Signed remainder.
    data_t  quot_r;  // Quotient after special cases.
    data_t  rem_r;   // Remainder after special cases.

    // ********************
    // Sign correction
    // ********************
    assign prod_s = neg_prod_i ? (~prod_i + dword_t'(1)) : prod_i;
    assign quot_s = neg_quot_i ? (~quot_i + data_t'(1)) : quot_i;
    assign rem_s  = neg_rem_i  ? (~rem_i + data_t'(1))  : rem_i;  // Zero stays zero.

    // Special cases override the divider output.
    always_comb begin
        if (div0_i) begin
            quot_r = '1;      // All ones.
            rem_r  = rs1_i;   // Dividend unchanged.
        end else if (ovf_i) begin
            quot_r = rs1_i;   // Most negative value.
            rem_r  = '0;
        end else begin
            quot_r = quot_s;
            rem_r  = rem_s;
        end
    end

    // ********************
    // Output mux
    // ********************
    always_comb begin
        case (funct3_i)
            MUL:    c_o = prod_s[DATA_WIDTH-1:0];              // Low word.
            MULH,
            MULHSU,
            MULHU:  c_o = prod_s[2*DATA_WIDTH-1:DATA_WIDTH];   // High word.
            DIV,
            DIVU:   c_o = quot_r;
            REM,
            REMU:   c_o = rem_r;
            default: c_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the multiply/divide testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_muldiv \
        -o sim_muldiv; then
    echo "Verilator build failed"
    exit 1
fi
./obj_dir/sim_muldiv > sim.log 2>&1
run_status=$?
cat sim.log
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tb.f
muldiv_pkg.sv
operand_prep.sv
div_restoring.sv
muldiv_execute.sv
result_select.sv
muldiv_top.sv
tb_muldiv.sv

//--- tb_muldiv.sv
//********************
// Testbench for the multiply/divide unit. Random and directed
// operations checked against a behavioural M extension model.
//********************

`default_nettype none

module tb_muldiv import muldiv_pkg::*; ();

    localparam data_t MOST_NEG  = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    localparam int    BUSY_WAIT = DIV_STEPS + 8;  // Cycles allowed for busy to fall.

    logic       clk, rstLow, start, busy;
    data_t      rs1, rs2, c;
    muldiv_op_e funct3;
    data_t      last_a, last_b;  // Magnitudes of the last divider run.

    muldiv_top DUT (
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .funct3_i (funct3),
        .start_i  (start),
        .clk      (clk),
        .rstLow   (rstLow),
        .c_o      (c),
        .busy_o   (busy)
    );

    always #2 clk = ~clk;  // Period 4.

    // ********************
    // Reference model
    // ********************
    function automatic data_t magnitude(input data_t v, input logic sgn);
        return (sgn && v[DATA_WIDTH-1]) ? data_t'(0) - v : v;
    endfunction

    // True when the request must start a divider run.
    function automatic logic expect_run(input muldiv_op_e op, input data_t a, input data_t b);
        logic sgn;
        sgn = op inside {DIV, REM};
        if (!(op inside {DIV, DIVU, REM, REMU}) || b == '0) return 1'b0;
        if (sgn && a == MOST_NEG && b == '1) return 1'b0;  // Overflow case.
        return (magnitude(a, sgn) != last_a) || (magnitude(b, sgn) != last_b);
    endfunction

    function automatic data_t model_result(input muldiv_op_e op, input data_t a, input data_t b);
        longint sa, sb;
        dword_t p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        if (op inside {DIV, DIVU, REM, REMU} && b == '0) return (op inside {DIV, DIVU}) ? '1 : a;
        if (op inside {DIV, REM} && a == MOST_NEG && b == '1) return (op == DIV) ? a : '0;
        case (op)
            MUL, MULH: p = dword_t'(sa * sb);
            MULHSU:    p = dword_t'(sa) * dword_t'(b);  // Signed times unsigned.
            MULHU:     p = dword_t'(a) * dword_t'(b);
            DIV:       p = dword_t'(sa / sb);           // Truncates toward zero.
            REM:       p = dword_t'(sa % sb);           // Sign of the dividend.
            DIVU:      p = dword_t'(a / b);
            default:   p = dword_t'(a % b);
        endcase
        if (op inside {MULH, MULHSU, MULHU}) return p[2*DATA_WIDTH-1:DATA_WIDTH];
        return p[DATA_WIDTH-1:0];
    endfunction

    function automatic data_t pick_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return '1;
            2:       return MOST_NEG;
            default: return data_t'($urandom);
        endcase
    endfunction

    // ********************
    // Checks and driving
    // ********************
    task automatic check_word(input data_t expected);
        if (c !== expected) begin
            $display("ERROR t=%0t c_o expected %h actual %h", $time, expected, c);
            $display("sim failed");
            $fatal(1, "Result mismatch");
        end
    endtask

    task automatic check_busy(input logic expected);
        if (busy !== expected) begin
            $display("ERROR t=%0t busy_o expected %b actual %b", $time, expected, busy);
            $display("sim failed");
            $fatal(1, "Busy mismatch");
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            n++;
            if (n > BUSY_WAIT) begin
                $display("Timeout: busy_o did not fall within %0d cycles", BUSY_WAIT);
                $display("sim failed");
                $fatal(1, "Busy timeout");
            end
            @(negedge clk);
        end
    endtask

    // One operation. With hold set the strobe stays high through the run.
    task automatic run_op(input data_t a, input data_t b, input muldiv_op_e op, input logic hold);
        logic  exp_busy;
        data_t exp_val;
        exp_busy = expect_run(op, a, b);
        exp_val  = model_result(op, a, b);
        @(posedge clk);
        rs1    <= a;
        rs2    <= b;
        funct3 <= op;
        start  <= 1'b1;
        @(negedge clk);
        check_busy(exp_busy);  // Start cycle.
        if (!exp_busy) begin
            check_word(exp_val);  // Result already there in the start cycle.
        end
        if (exp_busy) begin
            last_a = magnitude(a, op inside {DIV, REM});
            last_b = magnitude(b, op inside {DIV, REM});
        end
        if (!hold) begin
            @(posedge clk);
            start <= 1'b0;
        end
        wait_idle();
        check_word(exp_val);
        if (hold) begin
            @(negedge clk);
            check_busy(1'b0);  // No restart on matching operands.
            check_word(exp_val);
            @(posedge clk);
            start <= 1'b0;
        end
    endtask

    // ********************
    // Stimulus
    // ********************
    initial begin
        muldiv_op_e  op;
        data_t       a, b;
        clk    = 1'b0;
        rstLow = 1'b0;
        start  = 1'b0;
        rs1    = '0;
        rs2    = '0;
        funct3 = MUL;
        last_a = '0;  // Stored operands reset to zero.
        last_b = '0;
        void'($urandom(5893));
        repeat (4) @(posedge clk);
        rstLow <= 1'b1;
        @(negedge clk);
        check_busy(1'b0);
        repeat (300) begin
            op = muldiv_op_e'(3'($urandom_range(0, 3)));
            run_op(pick_operand(), pick_operand(), op, 1'b0);
        end
        repeat (200) begin
            do begin
                op = muldiv_op_e'(3'(4 + $urandom_range(0, 3)));
                a  = data_t'($urandom);
                b  = data_t'($urandom) >> $urandom_range(0, 28);  // Mixed divisor sizes.
            end while (!expect_run(op, a, b));
            run_op(a, b, op, 1'b0);
        end
        for (int k = 4; k < 8; k++) begin  // Zero divisor and overflow.
            op = muldiv_op_e'(3'(k));
            run_op(data_t'($urandom), '0, op, 1'b0);
            run_op(MOST_NEG, '0, op, 1'b0);
            run_op(MOST_NEG, '1, op, 1'b0);
        end
        do begin
            a = data_t'($urandom);
            b = data_t'($urandom) >> 8;
        end while (!expect_run(DIV, a, b));
        run_op(a, b, DIV, 1'b0);
        run_op(a, b, REM, 1'b0);              // Reuses the stored result.
        run_op(data_t'(0) - a, b, REM, 1'b0); // Same magnitudes.
        do begin
            a = data_t'($urandom);
            b = data_t'($urandom) >> 4;
        end while (!expect_run(DIVU, a, b));
        run_op(a, b, DIVU, 1'b0);
        run_op(a, b, REMU, 1'b0);
        do begin
            a = data_t'($urandom);
            b = data_t'($urandom) >> 12;
        end while (!expect_run(DIVU, a, b));
        run_op(a, b, DIVU, 1'b1);  // Held strobe.
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
